// File: filelist.f
hw/tinyrv1_pkg.sv
hw/regfile.sv
hw/alu.sv
hw/proc_dpath.sv
hw/proc_ctrl.sv
hw/proc_top.sv
testbench/proc_tb.sv

// File: testbench/proc_tb.sv
`timescale 1ns/1ps

module proc_tb;

  localparam tinyrv1_pkg::word_t boot_addr    = 32'h0000_0200;
  localparam int                 imem_depth   = 64;
  localparam logic [31:0]        nop_word     = 32'h0000_0013;
  localparam int                 reset_cycles = 10;

  logic                   clk;
  logic                   rst_n;
  logic                   imemreq_val;
  tinyrv1_pkg::word_t     imemreq_addr;
  tinyrv1_pkg::word_t     imemresp_data;
  logic                   trace_wen;
  tinyrv1_pkg::reg_addr_t trace_waddr;
  tinyrv1_pkg::word_t     trace_wdata;

  logic [31:0]            imem [imem_depth];
  logic [31:0]            prog [$];
  tinyrv1_pkg::word_t     imem_offset;
  tinyrv1_pkg::word_t     model_regs [32];
  tinyrv1_pkg::reg_addr_t exp_waddr [$];
  tinyrv1_pkg::word_t     exp_wdata [$];
  tinyrv1_pkg::reg_addr_t got_waddr [$];
  tinyrv1_pkg::word_t     got_wdata [$];
  logic                   collecting;
  int                     error_count;
  int                     model_steps;
  int                     cycle_count;
  int                     cycle_budget = 20;

  proc_top #(
    .reset_addr (boot_addr)
  ) DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .imemreq_val   (imemreq_val),
    .imemreq_addr  (imemreq_addr),
    .imemresp_data (imemresp_data),
    .trace_wen     (trace_wen),
    .trace_waddr   (trace_waddr),
    .trace_wdata   (trace_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Combinational instruction memory with nop outside the program
  assign imem_offset   = imemreq_addr - boot_addr;
  assign imemresp_data = (imem_offset < imem_depth * 4) ? imem[imem_offset[7:2]] : nop_word;

  // Trace capture
  always @(negedge clk) begin
    if (collecting && trace_wen) begin
      got_waddr.push_back(trace_waddr);
      got_wdata.push_back(trace_wdata);
    end
  end

  // Watchdog whose budget grows with each test
  initial begin
    cycle_count = 0;
    while (cycle_count <= cycle_budget) begin
      @(posedge clk);
      cycle_count++;
    end
    error_count++;
    $display("Watchdog expired after %0d cycles, the DUT stopped making progress", cycle_count);
    $display("Simulation finished with %0d errors", error_count);
    $display("TEST FAIL");
    $finish;
  end

  // ====================
  // Encoders and model
  // ====================

  function automatic logic [31:0] enc_add(input int rd, input int rs1, input int rs2);
    return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_bne(input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b001, off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic write_model(input tinyrv1_pkg::reg_addr_t rd, input tinyrv1_pkg::word_t val);
    if (rd != '0) begin
      model_regs[rd] = val;
      exp_waddr.push_back(rd);
      exp_wdata.push_back(val);
    end
  endtask

  // Sequential execution of the program one instruction at a time
  task automatic run_model();
    tinyrv1_pkg::word_t pc;
    tinyrv1_pkg::word_t imm;
    logic [31:0]        w;
    int                 idx;
    pc = boot_addr;
    idx = 0;
    model_steps = 0;
    exp_waddr.delete();
    exp_wdata.delete();
    while ((idx < prog.size()) && (model_steps < 256)) begin
      w = prog[idx];
      model_steps++;
      if ((w[6:0] == 7'b0110011) && (w[14:12] == 3'b000) && (w[31:25] == 7'b0)) begin
        write_model(w[11:7], model_regs[w[19:15]] + model_regs[w[24:20]]);
        pc = pc + 4;
      end else if ((w[6:0] == 7'b0010011) && (w[14:12] == 3'b000)) begin
        imm = {{20{w[31]}}, w[31:20]};
        write_model(w[11:7], model_regs[w[19:15]] + imm);
        pc = pc + 4;
      end else if ((w[6:0] == 7'b1100011) && (w[14:12] == 3'b001)) begin
        imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        pc = (model_regs[w[19:15]] != model_regs[w[24:20]]) ? pc + imm : pc + 4;
      end else begin
        pc = pc + 4;
      end
      idx = (pc - boot_addr) >> 2;
    end
  endtask

  // ====================
  // Checks
  // ====================

  task automatic check_word(input string name, input tinyrv1_pkg::word_t got,
                            input tinyrv1_pkg::word_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_addr(input string name, input tinyrv1_pkg::reg_addr_t got,
                            input tinyrv1_pkg::reg_addr_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s", msg);
    error_count++;
  endtask

  task automatic load_program();
    for (int i = 0; i < imem_depth; i++) begin
      imem[i] <= (i < prog.size()) ? prog[i] : nop_word;
    end
  endtask

  task automatic compare_writes(input string name);
    int n;
    n = (got_waddr.size() < exp_waddr.size()) ? got_waddr.size() : exp_waddr.size();
    for (int i = 0; i < n; i++) begin
      check_addr($sformatf("trace_waddr[%0d]", i), got_waddr[i], exp_waddr[i]);
      check_word($sformatf("trace_wdata[%0d]", i), got_wdata[i], exp_wdata[i]);
    end
    if (got_waddr.size() < exp_waddr.size()) begin
      note_failure($sformatf("%s: %0d expected register writes never appeared", name,
                             exp_waddr.size() - got_waddr.size()));
    end
    if (got_waddr.size() > exp_waddr.size()) begin
      note_failure($sformatf("%s: %0d register writes appeared that should not happen", name,
                             got_waddr.size() - exp_waddr.size()));
    end
  endtask

  // Reset, run the loaded program and compare the trace with the model
  task automatic execute_program(input string name);
    int wait_cycles;
    $display("Running %s", name);
    run_model();
    cycle_budget = cycle_budget + reset_cycles + 60 + model_steps * 10;
    @(posedge clk);
    rst_n <= 1'b0;
    load_program();
    collecting = 1'b0;
    got_waddr.delete();
    got_wdata.delete();
    @(negedge clk);
    repeat (reset_cycles - 1) begin
      @(negedge clk);
      check_bit("trace_wen", trace_wen, 1'b0);
      check_bit("imemreq_val", imemreq_val, 1'b0);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    collecting = 1'b1;
    @(negedge clk);
    wait_cycles = 0;
    while (!imemreq_val && (wait_cycles < 20)) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!imemreq_val) begin
      note_failure($sformatf("%s: fetch never started after reset release", name));
    end else begin
      check_word("imemreq_addr", imemreq_addr, boot_addr);
      check_bit("trace_wen", trace_wen, 1'b0);
    end
    wait_cycles = 0;
    while ((got_waddr.size() < exp_waddr.size()) && (wait_cycles < model_steps * 10 + 10)) begin
      @(negedge clk);
      wait_cycles++;
    end
    // Room for late extra writes
    repeat (8) @(negedge clk);
    collecting = 1'b0;
    compare_writes(name);
  endtask

  // ====================
  // Directed tests
  // ====================

  task automatic test_reset();
    prog.delete();
    prog.push_back(enc_addi(1, 0, 7));
    execute_program("reset and first fetch");
  endtask

  task automatic test_independent_addi();
    prog.delete();
    prog.push_back(enc_addi(1, 0, 5));
    prog.push_back(enc_addi(2, 0, -3));
    prog.push_back(enc_addi(3, 0, 100));
    prog.push_back(enc_addi(4, 0, 2047));
    prog.push_back(enc_addi(5, 0, -2048));
    prog.push_back(enc_addi(6, 0, 1));
    execute_program("independent addi");
  endtask

  task automatic test_bypass_distances();
    prog.delete();
    prog.push_back(enc_addi(1, 0, 3));
    prog.push_back(enc_addi(2, 0, 10));
    // Distance one through X
    prog.push_back(enc_add(3, 1, 2));
    prog.push_back(enc_add(4, 3, 3));
    // Distance two through M
    prog.push_back(enc_add(5, 4, 1));
    prog.push_back(enc_addi(9, 0, 1));
    prog.push_back(enc_add(6, 5, 2));
    // Distance three through W
    prog.push_back(enc_add(7, 6, 6));
    prog.push_back(enc_addi(10, 0, 2));
    prog.push_back(enc_addi(11, 0, 3));
    prog.push_back(enc_add(8, 7, 1));
    prog.push_back(enc_addi(12, 8, -1));
    prog.push_back(enc_add(13, 12, 11));
    execute_program("bypass distances");
  endtask

  task automatic test_register_x0();
    prog.delete();
    prog.push_back(enc_addi(0, 0, 55));
    prog.push_back(enc_add(1, 0, 0));
    prog.push_back(enc_addi(0, 1, 9));
    prog.push_back(enc_addi(2, 0, 4));
    prog.push_back(enc_add(3, 0, 2));
    execute_program("register x0");
  endtask

  task automatic test_branches();
    prog.delete();
    prog.push_back(enc_addi(1, 0, 1));
    prog.push_back(enc_addi(2, 0, 2));
    prog.push_back(enc_bne(1, 2, 12));
    prog.push_back(enc_addi(3, 0, 11));
    prog.push_back(enc_addi(4, 0, 12));
    prog.push_back(enc_addi(5, 0, 13));
    prog.push_back(enc_bne(1, 1, 8));
    prog.push_back(enc_addi(6, 0, 14));
    prog.push_back(enc_addi(7, 0, 15));
    // Short countdown loop
    prog.push_back(enc_addi(8, 0, 3));
    prog.push_back(enc_addi(8, 8, -1));
    prog.push_back(enc_bne(8, 0, -4));
    prog.push_back(enc_addi(9, 8, 20));
    execute_program("branches");
  endtask

  task automatic test_random_mix();
    int rd;
    int rs1;
    int rs2;
    int imm;
    prog.delete();
    for (int r = 1; r <= 4; r++) begin
      prog.push_back(enc_addi(r, 0, $urandom_range(0, 4095)));
    end
    repeat (24) begin
      rd  = $urandom_range(0, 4);
      rs1 = $urandom_range(0, 4);
      rs2 = $urandom_range(0, 4);
      imm = $urandom_range(0, 4095);
      if ($urandom_range(0, 1) == 0) begin
        prog.push_back(enc_add(rd, rs1, rs2));
      end else begin
        prog.push_back(enc_addi(rd, rs1, imm));
      end
    end
    execute_program("random mix");
  endtask

  initial begin
    void'($urandom(15593));
    rst_n       = 1'b0;
    collecting  = 1'b0;
    error_count = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    prog.delete();
    load_program();
    test_reset();
    test_independent_addi();
    test_bypass_distances();
    test_register_x0();
    test_branches();
    test_random_mix();
    $display("Simulation finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: hw/proc_top.sv
`timescale 1ns/1ps

module proc_top #(
  parameter tinyrv1_pkg::word_t reset_addr = '0
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // Instruction fetch
  output logic                   imemreq_val,
  output tinyrv1_pkg::word_t     imemreq_addr,
  input  tinyrv1_pkg::word_t     imemresp_data,

  // Writeback trace
  output logic                   trace_wen,
  output tinyrv1_pkg::reg_addr_t trace_waddr,
  output tinyrv1_pkg::word_t     trace_wdata
);

  // Control to datapath
  logic                   c2d_reg_en_F;
  tinyrv1_pkg::pc_sel_e   c2d_pc_sel_F;
  logic                   c2d_reg_en_D;
  tinyrv1_pkg::byp_sel_e  c2d_op1_byp_sel_D;
  tinyrv1_pkg::byp_sel_e  c2d_op2_byp_sel_D;
  logic                   c2d_op2_sel_D;
  logic                   c2d_alu_fn_X;
  logic                   c2d_rf_wen_W;
  tinyrv1_pkg::reg_addr_t c2d_rf_waddr_W;

  // Datapath to control
  tinyrv1_pkg::inst_t     d2c_inst;
  logic                   d2c_eq_X;

  proc_ctrl u_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .d2c_inst          (d2c_inst),
    .d2c_eq_X          (d2c_eq_X),
    .c2d_reg_en_F      (c2d_reg_en_F),
    .c2d_pc_sel_F      (c2d_pc_sel_F),
    .c2d_reg_en_D      (c2d_reg_en_D),
    .c2d_op1_byp_sel_D (c2d_op1_byp_sel_D),
    .c2d_op2_byp_sel_D (c2d_op2_byp_sel_D),
    .c2d_op2_sel_D     (c2d_op2_sel_D),
    .c2d_alu_fn_X      (c2d_alu_fn_X),
    .c2d_rf_wen_W      (c2d_rf_wen_W),
    .c2d_rf_waddr_W    (c2d_rf_waddr_W),
    .imemreq_val       (imemreq_val),
    .trace_wen         (trace_wen),
    .trace_waddr       (trace_waddr)
  );

  proc_dpath #(
    .reset_addr (reset_addr)
  ) u_dpath (
    .clk               (clk),
    .rst_n             (rst_n),
    .imemreq_addr      (imemreq_addr),
    .imemresp_data     (imemresp_data),
    .c2d_reg_en_F      (c2d_reg_en_F),
    .c2d_pc_sel_F      (c2d_pc_sel_F),
    .c2d_reg_en_D      (c2d_reg_en_D),
    .c2d_op1_byp_sel_D (c2d_op1_byp_sel_D),
    .c2d_op2_byp_sel_D (c2d_op2_byp_sel_D),
    .c2d_op2_sel_D     (c2d_op2_sel_D),
    .c2d_alu_fn_X      (c2d_alu_fn_X),
    .c2d_rf_wen_W      (c2d_rf_wen_W),
    .c2d_rf_waddr_W    (c2d_rf_waddr_W),
    .d2c_inst          (d2c_inst),
    .d2c_eq_X          (d2c_eq_X),
    .trace_wdata       (trace_wdata)
  );

endmodule

// File: hw/proc_ctrl.sv
`timescale 1ns/1ps

module proc_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,

  // Status from datapath
  input  tinyrv1_pkg::inst_t     d2c_inst,
  input  logic                   d2c_eq_X,

  // Selects to datapath
  output logic                   c2d_reg_en_F,
  output tinyrv1_pkg::pc_sel_e   c2d_pc_sel_F,
  output logic                   c2d_reg_en_D,
  output tinyrv1_pkg::byp_sel_e  c2d_op1_byp_sel_D,
  output tinyrv1_pkg::byp_sel_e  c2d_op2_byp_sel_D,
  output logic                   c2d_op2_sel_D,
  output logic                   c2d_alu_fn_X,
  output logic                   c2d_rf_wen_W,
  output tinyrv1_pkg::reg_addr_t c2d_rf_waddr_W,

  // Fetch request and writeback trace
  output logic                   imemreq_val,
  output logic                   trace_wen,
  output tinyrv1_pkg::reg_addr_t trace_waddr
);

  logic                   val_F;
  logic                   val_D;
  logic                   val_X;
  logic                   val_M;
  logic                   val_W;

  logic                   is_add_D;
  logic                   is_addi_D;
  logic                   is_bne_D;
  logic                   wen_D;
  tinyrv1_pkg::reg_addr_t rd_D;
  tinyrv1_pkg::reg_addr_t rs1_D;
  tinyrv1_pkg::reg_addr_t rs2_D;

  logic                   wen_X;
  logic                   wen_M;
  logic                   wen_W;
  tinyrv1_pkg::reg_addr_t rd_X;
  tinyrv1_pkg::reg_addr_t rd_M;
  tinyrv1_pkg::reg_addr_t rd_W;
  logic                   br_X;
  logic                   taken_X;

  logic                   wr_X;
  logic                   wr_M;
  logic                   wr_W;

  // ====================
  // Decode
  // ====================

  // One view per instruction format
  assign is_add_D  = (d2c_inst.r.opcode == tinyrv1_pkg::OP_ADD) &&
                     (d2c_inst.r.funct3 == tinyrv1_pkg::F3_ADD) &&
                     (d2c_inst.r.funct7 == tinyrv1_pkg::F7_ADD);
  assign is_addi_D = (d2c_inst.i.opcode == tinyrv1_pkg::OP_ADDI) &&
                     (d2c_inst.i.funct3 == tinyrv1_pkg::F3_ADDI);
  assign is_bne_D  = (d2c_inst.b.opcode == tinyrv1_pkg::OP_BNE) &&
                     (d2c_inst.b.funct3 == tinyrv1_pkg::F3_BNE);

  assign rd_D  = d2c_inst.i.rd;
  assign rs1_D = d2c_inst.r.rs1;
  assign rs2_D = d2c_inst.r.rs2;

  // Writes to x0 are dropped here
  // Unknown opcodes never write
  assign wen_D = (is_add_D || is_addi_D) && (rd_D != '0);

  assign c2d_op2_sel_D = is_addi_D;

  // ====================
  // Bypass
  // ====================

  assign wr_X = val_X && wen_X;
  assign wr_M = val_M && wen_M;
  assign wr_W = val_W && wen_W;

  function automatic tinyrv1_pkg::byp_sel_e byp_pick(
    input tinyrv1_pkg::reg_addr_t rs,
    input logic                   x_wr,
    input tinyrv1_pkg::reg_addr_t x_rd,
    input logic                   m_wr,
    input tinyrv1_pkg::reg_addr_t m_rd,
    input logic                   w_wr,
    input tinyrv1_pkg::reg_addr_t w_rd
  );
    if (x_wr && (x_rd == rs)) begin
      return tinyrv1_pkg::BYP_X;
    end else if (m_wr && (m_rd == rs)) begin
      return tinyrv1_pkg::BYP_M;
    end else if (w_wr && (w_rd == rs)) begin
      return tinyrv1_pkg::BYP_W;
    end
    return tinyrv1_pkg::BYP_RF;
  endfunction

  assign c2d_op1_byp_sel_D = byp_pick(rs1_D, wr_X, rd_X, wr_M, rd_M, wr_W, rd_W);
  assign c2d_op2_byp_sel_D = byp_pick(rs2_D, wr_X, rd_X, wr_M, rd_M, wr_W, rd_W);

  // ====================
  // Branch and fetch
  // ====================

  assign taken_X      = val_X && br_X && !d2c_eq_X;
  assign c2d_pc_sel_F = taken_X ? tinyrv1_pkg::PC_BRANCH : tinyrv1_pkg::PC_PLUS4;
  assign c2d_alu_fn_X = br_X;

  assign imemreq_val  = val_F;
  assign c2d_reg_en_F = val_F;
  assign c2d_reg_en_D = val_F;

  // ====================
  // Stage state
  // ====================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      val_F <= 1'b0;
      val_D <= 1'b0;
      val_X <= 1'b0;
      val_M <= 1'b0;
      val_W <= 1'b0;
      wen_X <= 1'b0;
      wen_M <= 1'b0;
      wen_W <= 1'b0;
      rd_X  <= '0;
      rd_M  <= '0;
      rd_W  <= '0;
      br_X  <= 1'b0;
    end else begin
      val_F <= 1'b1;
      // Taken branch kills the two younger slots
      val_D <= val_F && !taken_X;
      val_X <= val_D && !taken_X;
      val_M <= val_X;
      val_W <= val_M;
      wen_X <= wen_D;
      wen_M <= wen_X;
      wen_W <= wen_M;
      rd_X  <= rd_D;
      rd_M  <= rd_X;
      rd_W  <= rd_M;
      br_X  <= is_bne_D;
    end
  end

  // Writeback
  assign c2d_rf_wen_W   = wr_W;
  assign c2d_rf_waddr_W = rd_W;
  assign trace_wen      = wr_W;
  assign trace_waddr    = rd_W;

  // Forwarded values come from instructions that really retire
  a_byp_x_retires: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((c2d_op1_byp_sel_D == tinyrv1_pkg::BYP_X) ||
     (c2d_op2_byp_sel_D == tinyrv1_pkg::BYP_X)) |-> ##2 c2d_rf_wen_W
  );

  a_byp_m_retires: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((c2d_op1_byp_sel_D == tinyrv1_pkg::BYP_M) ||
     (c2d_op2_byp_sel_D == tinyrv1_pkg::BYP_M)) |-> ##1 c2d_rf_wen_W
  );

  // The two slots squashed by a redirect never reach the register file
  a_branch_squash: assert property (
    @(posedge clk) disable iff (!rst_n)
    (c2d_pc_sel_F == tinyrv1_pkg::PC_BRANCH) |-> ##3 !c2d_rf_wen_W ##1 !c2d_rf_wen_W
  );

endmodule

// File: hw/proc_dpath.sv
`timescale 1ns/1ps

module proc_dpath #(
  parameter tinyrv1_pkg::word_t reset_addr = '0
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // Instruction fetch
  output tinyrv1_pkg::word_t     imemreq_addr,
  input  tinyrv1_pkg::word_t     imemresp_data,

  // Control
  input  logic                   c2d_reg_en_F,
  input  tinyrv1_pkg::pc_sel_e   c2d_pc_sel_F,
  input  logic                   c2d_reg_en_D,
  input  tinyrv1_pkg::byp_sel_e  c2d_op1_byp_sel_D,
  input  tinyrv1_pkg::byp_sel_e  c2d_op2_byp_sel_D,
  input  logic                   c2d_op2_sel_D,
  input  logic                   c2d_alu_fn_X,
  input  logic                   c2d_rf_wen_W,
  input  tinyrv1_pkg::reg_addr_t c2d_rf_waddr_W,

  // Status
  output tinyrv1_pkg::inst_t     d2c_inst,
  output logic                   d2c_eq_X,

  // Writeback trace
  output tinyrv1_pkg::word_t     trace_wdata
);

  tinyrv1_pkg::word_t pc_F;
  tinyrv1_pkg::word_t pc_next_F;
  tinyrv1_pkg::word_t pc_plus4_F;

  tinyrv1_pkg::inst_t inst_D;
  tinyrv1_pkg::word_t pc_D;
  tinyrv1_pkg::word_t rs1_data_D;
  tinyrv1_pkg::word_t rs2_data_D;
  tinyrv1_pkg::word_t op1_byp_D;
  tinyrv1_pkg::word_t op2_byp_D;
  tinyrv1_pkg::word_t op2_D;
  tinyrv1_pkg::word_t imm_i_D;
  tinyrv1_pkg::word_t imm_b_D;
  tinyrv1_pkg::word_t br_target_D;

  tinyrv1_pkg::word_t op1_X;
  tinyrv1_pkg::word_t op2_X;
  tinyrv1_pkg::word_t br_target_X;
  tinyrv1_pkg::word_t result_X;

  tinyrv1_pkg::word_t result_M;
  tinyrv1_pkg::word_t result_W;

  // Newest-first operand choice, the select already carries the priority
  function automatic tinyrv1_pkg::word_t byp_mux(
    input tinyrv1_pkg::byp_sel_e sel,
    input tinyrv1_pkg::word_t    rf,
    input tinyrv1_pkg::word_t    x,
    input tinyrv1_pkg::word_t    m,
    input tinyrv1_pkg::word_t    w
  );
    case (sel)
      tinyrv1_pkg::BYP_X: return x;
      tinyrv1_pkg::BYP_M: return m;
      tinyrv1_pkg::BYP_W: return w;
      default:            return rf;
    endcase
  endfunction

  // ====================
  // Stage F
  // ====================

  assign pc_plus4_F = pc_F + 32'd4;

  always_comb begin
    case (c2d_pc_sel_F)
      tinyrv1_pkg::PC_BRANCH: pc_next_F = br_target_X;
      default:                pc_next_F = pc_plus4_F;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_F <= reset_addr;
    end else if (c2d_reg_en_F) begin
      pc_F <= pc_next_F;
    end
  end

  assign imemreq_addr = pc_F;

  // F/D register
  always_ff @(posedge clk) begin
    if (c2d_reg_en_D) begin
      inst_D <= imemresp_data;
      pc_D   <= pc_F;
    end
  end

  assign d2c_inst = inst_D;

  // ====================
  // Stage D
  // ====================

  regfile u_regfile (
    .clk    (clk),
    .wen    (c2d_rf_wen_W),
    .waddr  (c2d_rf_waddr_W),
    .wdata  (result_W),
    .raddr0 (inst_D.r.rs1),
    .rdata0 (rs1_data_D),
    .raddr1 (inst_D.r.rs2),
    .rdata1 (rs2_data_D)
  );

  // Immediates through the I and B views
  assign imm_i_D = {{20{inst_D.i.imm12[11]}}, inst_D.i.imm12};
  assign imm_b_D = {{19{inst_D.b.imm12}}, inst_D.b.imm12, inst_D.b.imm11,
                    inst_D.b.imm10_5, inst_D.b.imm4_1, 1'b0};

  assign br_target_D = pc_D + imm_b_D;

  assign op1_byp_D = byp_mux(c2d_op1_byp_sel_D, rs1_data_D, result_X, result_M, result_W);
  assign op2_byp_D = byp_mux(c2d_op2_byp_sel_D, rs2_data_D, result_X, result_M, result_W);

  // addi takes the immediate as second operand
  assign op2_D = c2d_op2_sel_D ? imm_i_D : op2_byp_D;

  // D/X register
  always_ff @(posedge clk) begin
    op1_X       <= op1_byp_D;
    op2_X       <= op2_D;
    br_target_X <= br_target_D;
  end

  // ====================
  // Stage X
  // ====================

  alu u_alu (
    .fn  (c2d_alu_fn_X),
    .in0 (op1_X),
    .in1 (op2_X),
    .out (result_X)
  );

  assign d2c_eq_X = result_X[0];

  // ====================
  // Stages M and W
  // ====================

  // No data memory, M only carries the result
  always_ff @(posedge clk) begin
    result_M <= result_X;
    result_W <= result_M;
  end

  assign trace_wdata = result_W;

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic               fn,
  input  tinyrv1_pkg::word_t in0,
  input  tinyrv1_pkg::word_t in1,
  output tinyrv1_pkg::word_t out
);

  tinyrv1_pkg::word_t sum;
  logic               eq;

  // ====================
  // Shared operand pair
  // ====================

  assign sum = in0 + in1;
  assign eq  = (in0 == in1);

  // ====================
  // Function select
  // ====================

  // fn 0 adds, fn 1 compares; compare result sits in bit 0
  always_comb begin
    if (fn) begin
      out    = '0;
      out[0] = eq;
    end else begin
      out = sum;
    end
  end

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic                   clk,

  // Write port
  input  logic                   wen,
  input  tinyrv1_pkg::reg_addr_t waddr,
  input  tinyrv1_pkg::word_t     wdata,

  // Read ports
  input  tinyrv1_pkg::reg_addr_t raddr0,
  output tinyrv1_pkg::word_t     rdata0,
  input  tinyrv1_pkg::reg_addr_t raddr1,
  output tinyrv1_pkg::word_t     rdata1
);

  tinyrv1_pkg::word_t regs [32];

  // x0 storage is cleared on every clock
  // Writes aimed at x0 are discarded
  always_ff @(posedge clk) begin
    regs[0] <= '0;
    if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Combinational reads
  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];

  // A read of x0 returns zero on either port
  a_x0_zero_0: assert property (
    @(posedge clk)
    (raddr0 == '0) |-> (rdata0 == '0)
  );

  a_x0_zero_1: assert property (
    @(posedge clk)
    (raddr1 == '0) |-> (rdata1 == '0)
  );

endmodule

// File: hw/tinyrv1_pkg.sv
package tinyrv1_pkg;

  // ====================
  // Basic types
  // ====================

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // ====================
  // Encodings
  // ====================

  // Major opcodes
  localparam logic [6:0] OP_ADD  = 7'b0110011;
  localparam logic [6:0] OP_ADDI = 7'b0010011;
  localparam logic [6:0] OP_BNE  = 7'b1100011;

  // Function fields for the supported subset
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_ADDI = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [6:0] F7_ADD  = 7'b0000000;

  // Three views of one instruction word
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
    } i;
    // Branch offset is scattered over the word
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
  } inst_t;

  // ====================
  // Datapath selects
  // ====================

  typedef enum logic [1:0] {
    BYP_RF = 2'd0,
    BYP_X  = 2'd1,
    BYP_M  = 2'd2,
    BYP_W  = 2'd3
  } byp_sel_e;

  typedef enum logic [1:0] {
    PC_PLUS4  = 2'd0,
    PC_BRANCH = 2'd1
  } pc_sel_e;

endpackage
